/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f list.f --top-module mem_stage_tb \
		-Mdir obj_dir -o mem_stage_sim

run: compile
	./obj_dir/mem_stage_sim > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* bench/mem_stage_chk.sv */
`timescale 1ns/1ns

module mem_stage_chk (
    input logic clk,
    input logic rst,
    input logic req_i,
    input logic ack_o,
    input logic busy_o,
    input logic awvalid,
    input logic awready,
    input logic arvalid,
    input logic arready,
    input logic bvalid,
    input logic rvalid
);

    // The stage answers only a request that is still up
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack_o) |-> req_i)
        else $error("ack_o rose while req_i was low");

    // Controller never issues a write and a read together
    no_mixed_access: assert property (@(posedge clk) disable iff (rst) !(awvalid && arvalid))
        else $error("awvalid and arvalid high in the same cycle");

    aw_held: assert property (@(posedge clk) disable iff (rst) awvalid && !awready |=> awvalid)
        else $error("awvalid dropped before awready");

    ar_held: assert property (@(posedge clk) disable iff (rst) arvalid && !arready |=> arvalid)
        else $error("arvalid dropped before arready");

    // Busy ends only after a response transfer and goes straight to ack
    busy_ends_in_ack: assert property (@(posedge clk) disable iff (rst)
        $fell(busy_o) |-> ack_o && $past(bvalid || rvalid))
        else $error("busy_o fell without a response transfer into ack_o");

endmodule

/* bench/mem_stage_tb.sv */
`timescale 1ns/1ns
`include "mem_params.svh"

module mem_stage_tb;

    localparam int TIMEOUT = 50;
    localparam int SHADOW_BYTES = 4 << `MEM_SRAM_ADDR_BITS;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [2:0] F3_B  = 3'd0;
    localparam logic [2:0] F3_H  = 3'd1;
    localparam logic [2:0] F3_W  = 3'd2;
    localparam logic [2:0] F3_BU = 3'd4;
    localparam logic [2:0] F3_HU = 3'd5;

    typedef struct {
        rv_pkg::word_t     inst;
        rv_pkg::word_t     addr;
        rv_pkg::word_t     sdata;
        rv_pkg::reg_addr_t rd;
        bit                rnd;
        rv_pkg::word_t     exp;
    } entry_t;

    logic              clk = 1'b0;
    logic              rst;
    logic              req_i;
    logic              ack_o;
    logic              busy_o;
    rv_pkg::word_t     pc_i;
    rv_pkg::word_t     inst_i;
    rv_pkg::word_t     addr_i;
    rv_pkg::word_t     store_data_i;
    rv_pkg::reg_addr_t rd_addr_i;
    rv_pkg::word_t     pc_o;
    rv_pkg::word_t     load_data_o;
    rv_pkg::reg_addr_t rd_addr_o;

    entry_t      tests [$];
    logic [7:0]  shadow [SHADOW_BYTES];
    logic [31:0] lfsr;
    int          errors;
    int          ran;
    bit          timed_out;
    bit          saw_busy;

    mem_stage_top mem_stage_top_i (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .ack_o        (ack_o),
        .busy_o       (busy_o),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .rd_addr_i    (rd_addr_i),
        .pc_o         (pc_o),
        .load_data_o  (load_data_o),
        .rd_addr_o    (rd_addr_o)
    );

    bind mem_stage_top mem_stage_chk mem_stage_chk_i (
        .clk     (clk),
        .rst     (rst),
        .req_i   (req_i),
        .ack_o   (ack_o),
        .busy_o  (busy_o),
        .awvalid (axi_if.awvalid),
        .awready (axi_if.awready),
        .arvalid (axi_if.arvalid),
        .arready (axi_if.arready),
        .bvalid  (axi_if.bvalid),
        .rvalid  (axi_if.rvalid)
    );

    always #10 clk = ~clk;

    function automatic rv_pkg::word_t encode_inst(input logic [6:0] opcode,
                                                  input logic [2:0] funct3);
        return {17'b0, funct3, 5'b0, opcode};
    endfunction

    // Galois LFSR stepped once per bit handed out
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    function automatic int access_bytes(input logic [2:0] funct3);
        return 1 << funct3[1:0];
    endfunction

    task automatic shadow_store(input rv_pkg::word_t addr, input logic [2:0] funct3,
                                input rv_pkg::word_t data);
        int base;
        base = int'(addr[`MEM_SRAM_ADDR_BITS+1:0]);
        for (int b = 0; b < access_bytes(funct3); b++) begin
            shadow[base + b] = data[8*b +: 8];
        end
    endtask

    // Little-endian read, then sign fill unless funct3[2] asks for zero fill
    function automatic rv_pkg::word_t shadow_load(input rv_pkg::word_t addr,
                                                  input logic [2:0] funct3);
        rv_pkg::word_t val;
        int            n;
        int            base;
        n    = access_bytes(funct3);
        base = int'(addr[`MEM_SRAM_ADDR_BITS+1:0]);
        val  = '0;
        for (int b = n - 1; b >= 0; b--) begin
            val = {val[23:0], shadow[base + b]};
        end
        if (!funct3[2] && n < 4 && val[8*n-1]) begin
            val = val | (~32'h0 << (8 * n));
        end
        return val;
    endfunction

    task automatic check_word(input string name, input rv_pkg::word_t exp,
                              input rv_pkg::word_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input rv_pkg::reg_addr_t exp,
                             input rv_pkg::reg_addr_t act);
        if (act !== exp) begin
            $display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic wait_ack(input logic level);
        int cnt;
        cnt = 0;
        do begin
            @(negedge clk);
            if (busy_o === 1'b1) begin
                saw_busy = 1'b1;
            end
            cnt++;
        end while (ack_o !== level && cnt < TIMEOUT);
        if (ack_o !== level) begin
            $display("Timeout: ack_o did not go %s within %0d cycles",
                     level ? "high" : "low", TIMEOUT);
            errors++;
            timed_out = 1'b1;
        end
    endtask

    task automatic add_entry(input rv_pkg::word_t inst, input rv_pkg::word_t addr,
                             input rv_pkg::word_t sdata, input rv_pkg::reg_addr_t rd,
                             input bit rnd);
        entry_t e;
        e.inst  = inst;
        e.addr  = addr;
        e.sdata = sdata;
        e.rd    = rd;
        e.rnd   = rnd;
        e.exp   = '0;
        tests.push_back(e);
    endtask

    task automatic build_table();
        // Whole words, then two neighbours kept apart
        add_entry(encode_inst(OP_STORE, F3_W), 32'h040, 32'h1234_5678, 5'd1, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h040, '0, 5'd2, 1'b0);
        add_entry(encode_inst(OP_STORE, F3_W), 32'h044, '0, 5'd3, 1'b1);
        add_entry(encode_inst(OP_STORE, F3_W), 32'h048, '0, 5'd4, 1'b1);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h044, '0, 5'd5, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h048, '0, 5'd6, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h040, '0, 5'd7, 1'b0);
        // Byte and halfword stores into known words
        add_entry(encode_inst(OP_STORE, F3_W), 32'h080, 32'h8091_7F22, 5'd8, 1'b0);
        add_entry(encode_inst(OP_STORE, F3_B), 32'h081, '0, 5'd9, 1'b1);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h080, '0, 5'd10, 1'b0);
        add_entry(encode_inst(OP_STORE, F3_B), 32'h083, '0, 5'd11, 1'b1);
        add_entry(encode_inst(OP_STORE, F3_B), 32'h080, '0, 5'd12, 1'b1);
        add_entry(encode_inst(OP_STORE, F3_B), 32'h082, '0, 5'd13, 1'b1);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h080, '0, 5'd14, 1'b0);
        add_entry(encode_inst(OP_STORE, F3_W), 32'h084, 32'h7F80_80FF, 5'd15, 1'b0);
        add_entry(encode_inst(OP_STORE, F3_H), 32'h086, '0, 5'd16, 1'b1);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h084, '0, 5'd17, 1'b0);
        add_entry(encode_inst(OP_STORE, F3_H), 32'h084, 32'h0000_0001, 5'd18, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h084, '0, 5'd19, 1'b0);
        // Sign and zero extension of every lane
        add_entry(encode_inst(OP_STORE, F3_W), 32'h090, 32'h8F7E_F10C, 5'd20, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_B), 32'h090, '0, 5'd21, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_B), 32'h091, '0, 5'd22, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_B), 32'h092, '0, 5'd23, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_B), 32'h093, '0, 5'd24, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_BU), 32'h091, '0, 5'd25, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_BU), 32'h093, '0, 5'd26, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_H), 32'h090, '0, 5'd27, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_H), 32'h092, '0, 5'd28, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_HU), 32'h090, '0, 5'd29, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_HU), 32'h092, '0, 5'd30, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_H), 32'h084, '0, 5'd31, 1'b0);
        add_entry(encode_inst(OP_LOAD, F3_BU), 32'h080, '0, 5'd0, 1'b0);
        // OP-IMM words must not touch memory
        add_entry(32'h0051_0093, 32'h090, '0, 5'd1, 1'b1);
        add_entry(encode_inst(OP_IMM, F3_W), 32'h090, '0, 5'd2, 1'b1);
        add_entry(encode_inst(OP_LOAD, F3_W), 32'h090, '0, 5'd3, 1'b0);
    endtask

    task automatic apply_entry(input int idx);
        entry_t        e;
        rv_pkg::word_t pc;
        int            gap;
        int            hold;
        int            err_before;
        bit            is_mem;
        e          = tests[idx];
        pc         = 32'h0000_1000 + 32'(4 * idx);
        gap        = int'(next_bits(2));
        hold       = int'(next_bits(2));
        err_before = errors;
        if (e.rnd) begin
            e.sdata = next_bits(32);
        end
        if (e.inst[6:0] == OP_LOAD) begin
            e.exp = shadow_load(e.addr, e.inst[14:12]);
        end
        // Only loads and stores pass through the bus access state
        is_mem     = (e.inst[6:0] == OP_LOAD) || (e.inst[6:0] == OP_STORE);
        tests[idx] = e;
        repeat (gap) @(posedge clk);
        saw_busy = 1'b0;
        @(posedge clk);
        req_i        <= 1'b1;
        pc_i         <= pc;
        inst_i       <= e.inst;
        addr_i       <= e.addr;
        store_data_i <= e.sdata;
        rd_addr_i    <= e.rd;
        wait_ack(1'b1);
        if (!timed_out) begin
            check_word("busy_o", rv_pkg::word_t'(is_mem), rv_pkg::word_t'(saw_busy));
            check_word("pc_o", pc, pc_o);
            check_reg("rd_addr_o", e.rd, rd_addr_o);
            check_word("load_data_o", e.exp, load_data_o);
            // Results must hold while req_i stays up
            repeat (hold) @(negedge clk);
            check_word("ack_o", 32'd1, rv_pkg::word_t'(ack_o));
            check_word("load_data_o", e.exp, load_data_o);
            @(posedge clk);
            req_i <= 1'b0;
            wait_ack(1'b0);
        end
        if (!timed_out && e.inst[6:0] == OP_STORE) begin
            shadow_store(e.addr, e.inst[14:12], e.sdata);
        end
        ran++;
        $display("test %0d inst %h addr %h: %s", idx, e.inst, e.addr,
                 (errors == err_before) ? "ok" : "failed");
    endtask

    initial begin
        rst          = 1'b1;
        req_i        = 1'b0;
        pc_i         = '0;
        inst_i       = '0;
        addr_i       = '0;
        store_data_i = '0;
        rd_addr_i    = '0;
        lfsr         = 32'h71bf506c;
        errors       = 0;
        ran          = 0;
        timed_out    = 1'b0;
        saw_busy     = 1'b0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_word("ack_o", '0, rv_pkg::word_t'(ack_o));
        check_word("busy_o", '0, rv_pkg::word_t'(busy_o));
        check_word("load_data_o", '0, load_data_o);
        check_word("pc_o", '0, pc_o);
        check_reg("rd_addr_o", '0, rd_addr_o);
        ran++;
        $display("test reset: %s", (errors == 0) ? "ok" : "failed");
        for (int i = 0; i < tests.size() && !timed_out; i++) begin
            apply_entry(i);
        end
        $display("%0d tests run, %0d errors", ran, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+source
source/rv_pkg.sv
source/bus_pkg.sv
source/axi_lite_if.sv
source/load_align.sv
source/store_mask_gen.sv
source/mem_access_ctrl.sv
source/axi_lite_sram.sv
source/mem_stage_top.sv
bench/mem_stage_chk.sv
bench/mem_stage_tb.sv

/* source/axi_lite_if.sv */
`timescale 1ns/1ns

interface axi_lite_if;

    // Write address and write data
    logic              awvalid;
    logic              awready;
    rv_pkg::word_t     awaddr;
    logic              wvalid;
    logic              wready;
    rv_pkg::word_t     wdata;
    bus_pkg::strb_t    wstrb;

    // Write response
    logic              bvalid;
    logic              bready;
    bus_pkg::resp_t    bresp;

    // Read address and read data
    logic              arvalid;
    logic              arready;
    rv_pkg::word_t     araddr;
    logic              rvalid;
    logic              rready;
    rv_pkg::word_t     rdata;
    bus_pkg::resp_t    rresp;

    modport master (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

    modport slave (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, bresp, arready, rvalid, rdata, rresp
    );

endinterface

/* source/axi_lite_sram.sv */
`timescale 1ns/1ns
`include "mem_params.svh"

module axi_lite_sram (
    input  logic       clk,
    input  logic       rst,
    axi_lite_if.slave  bus
);

    localparam int unsigned DEPTH = 1 << `MEM_SRAM_ADDR_BITS;
    localparam int unsigned CNT_W = $clog2(`MEM_SRAM_LATENCY + 1);

    typedef logic [`MEM_SRAM_ADDR_BITS-1:0] word_idx_t;
    typedef logic [CNT_W-1:0] lat_cnt_t;

    localparam lat_cnt_t LAT_LAST = lat_cnt_t'(`MEM_SRAM_LATENCY - 1);

    rv_pkg::word_t        mem [DEPTH];
    bus_pkg::sram_state_e state;
    lat_cnt_t             lat_cnt;
    logic                 is_write;
    logic                 aw_got;
    logic                 w_got;
    word_idx_t            idx_q;
    rv_pkg::word_t        wdata_q;
    bus_pkg::strb_t       wstrb_q;
    rv_pkg::word_t        rdata_q;
    logic                 aw_hs;
    logic                 w_hs;
    logic                 ar_hs;
    logic                 commit;
    word_idx_t            wr_idx;
    rv_pkg::word_t        wr_data;
    bus_pkg::strb_t       wr_strb;

    // Ready only in S_IDLE, and writes win over reads
    assign bus.awready = (state == bus_pkg::S_IDLE) && !aw_got;
    assign bus.wready  = (state == bus_pkg::S_IDLE) && !w_got;
    assign bus.arready = (state == bus_pkg::S_IDLE) && !aw_got && !w_got
                         && !bus.awvalid && !bus.wvalid;

    assign aw_hs = bus.awvalid && bus.awready;
    assign w_hs  = bus.wvalid && bus.wready;
    assign ar_hs = bus.arvalid && bus.arready;

    // Write goes ahead once both halves have arrived
    assign commit  = (aw_got || aw_hs) && (w_got || w_hs);
    assign wr_idx  = aw_got ? idx_q : bus.awaddr[`MEM_SRAM_ADDR_BITS+1:2];
    assign wr_data = w_got ? wdata_q : bus.wdata;
    assign wr_strb = w_got ? wstrb_q : bus.wstrb;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= bus_pkg::S_IDLE;
            lat_cnt  <= '0;
            is_write <= 1'b0;
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
        end else begin
            case (state)
                bus_pkg::S_IDLE: begin
                    if (aw_hs) begin
                        aw_got <= 1'b1;
                    end
                    if (w_hs) begin
                        w_got <= 1'b1;
                    end
                    if (commit) begin
                        aw_got   <= 1'b0;
                        w_got    <= 1'b0;
                        is_write <= 1'b1;
                        lat_cnt  <= '0;
                        state    <= bus_pkg::S_WAIT;
                    end else if (ar_hs) begin
                        is_write <= 1'b0;
                        lat_cnt  <= '0;
                        state    <= bus_pkg::S_WAIT;
                    end
                end
                bus_pkg::S_WAIT: begin
                    if (lat_cnt == LAT_LAST) begin
                        state <= bus_pkg::S_RESP;
                    end else begin
                        lat_cnt <= lat_cnt + lat_cnt_t'(1);
                    end
                end
                bus_pkg::S_RESP: begin
                    // Held here while the master stalls
                    if ((bus.bvalid && bus.bready) || (bus.rvalid && bus.rready)) begin
                        state <= bus_pkg::S_IDLE;
                    end
                end
                default: state <= bus_pkg::S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            idx_q <= bus.awaddr[`MEM_SRAM_ADDR_BITS+1:2];
        end else if (ar_hs) begin
            idx_q <= bus.araddr[`MEM_SRAM_ADDR_BITS+1:2];
        end
        if (w_hs) begin
            wdata_q <= bus.wdata;
            wstrb_q <= bus.wstrb;
        end
    end

    // Array with byte strobes and a registered read port
    always_ff @(posedge clk) begin
        if ((state == bus_pkg::S_IDLE) && commit) begin
            for (int b = 0; b < $bits(bus_pkg::strb_t); b++) begin
                if (wr_strb[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        if ((state == bus_pkg::S_WAIT) && (lat_cnt == LAT_LAST) && !is_write) begin
            rdata_q <= mem[idx_q];
        end
    end

    assign bus.bvalid = (state == bus_pkg::S_RESP) && is_write;
    assign bus.rvalid = (state == bus_pkg::S_RESP) && !is_write;
    assign bus.bresp  = bus_pkg::RESP_OKAY;
    assign bus.rresp  = bus_pkg::RESP_OKAY;
    assign bus.rdata  = rdata_q;

endmodule

/* source/bus_pkg.sv */
`include "mem_params.svh"

package bus_pkg;

    // One strobe bit per data byte
    typedef logic [`MEM_DATA_WIDTH/8-1:0] strb_t;

    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // SRAM slave states
    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_RESP
    } sram_state_e;

endpackage

/* source/load_align.sv */
`timescale 1ns/1ns

module load_align (
    input  rv_pkg::word_t        raw_i,
    input  logic [1:0]           addr_lo_i,
    input  rv_pkg::access_size_e size_i,
    input  logic                 sign_ext_i,
    output rv_pkg::word_t        data_o
);

    logic [7:0]  sel_byte;
    logic [15:0] sel_half;
    logic        fill;

    // Lane picked by the low address bits
    assign sel_byte = raw_i[{addr_lo_i, 3'b000} +: 8];
    assign sel_half = addr_lo_i[1] ? raw_i[31:16] : raw_i[15:0];

    always_comb begin
        fill = 1'b0;
        case (size_i)
            rv_pkg::SIZE_BYTE: begin
                fill   = sign_ext_i && sel_byte[7];
                data_o = {{24{fill}}, sel_byte};
            end
            rv_pkg::SIZE_HALF: begin
                fill   = sign_ext_i && sel_half[15];
                data_o = {{16{fill}}, sel_half};
            end
            default: begin
                data_o = raw_i;
            end
        endcase
    end

endmodule

/* source/mem_access_ctrl.sv */
`timescale 1ns/1ns

module mem_access_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 req_i,
    output logic                 ack_o,
    output logic                 busy_o,
    input  rv_pkg::word_t        pc_i,
    input  rv_pkg::word_t        inst_i,
    input  rv_pkg::word_t        addr_i,
    input  rv_pkg::word_t        store_data_i,
    input  rv_pkg::reg_addr_t    rd_addr_i,
    output rv_pkg::word_t        pc_o,
    output rv_pkg::reg_addr_t    rd_addr_o,
    output rv_pkg::access_size_e size_o,
    output logic                 sign_ext_o,
    output rv_pkg::access_kind_e kind_o,
    output rv_pkg::word_t        addr_o,
    output rv_pkg::word_t        store_data_o,
    input  bus_pkg::strb_t       wstrb_i,
    input  rv_pkg::word_t        wdata_i,
    input  rv_pkg::word_t        load_data_i,
    output rv_pkg::word_t        load_data_o,
    axi_lite_if.master           bus
);

    rv_pkg::ctrl_state_e  state;
    logic                 pending;
    rv_pkg::word_t        pc_q;
    rv_pkg::word_t        inst_q;
    rv_pkg::word_t        addr_q;
    rv_pkg::word_t        sdata_q;
    rv_pkg::reg_addr_t    rd_q;
    rv_pkg::word_t        load_q;
    logic                 awvalid_q;
    logic                 wvalid_q;
    logic                 arvalid_q;
    rv_pkg::opcode_t      opcode;
    rv_pkg::funct3_t      funct3;
    rv_pkg::access_kind_e kind;
    logic                 wr_done;
    logic                 rd_done;

    // Decode from the captured instruction
    assign opcode = inst_q[6:0];
    assign funct3 = inst_q[14:12];

    always_comb begin
        kind = rv_pkg::KIND_NONE;
        if (opcode == rv_pkg::OPCODE_LOAD) begin
            kind = rv_pkg::KIND_LOAD;
        end else if (opcode == rv_pkg::OPCODE_STORE) begin
            kind = rv_pkg::KIND_STORE;
        end
    end

    always_comb begin
        case (funct3[1:0])
            2'b00:   size_o = rv_pkg::SIZE_BYTE;
            2'b01:   size_o = rv_pkg::SIZE_HALF;
            default: size_o = rv_pkg::SIZE_WORD;
        endcase
    end

    // LBU and LHU set funct3[2]
    assign sign_ext_o = (kind == rv_pkg::KIND_LOAD) && !funct3[2];

    assign wr_done = bus.bvalid && bus.bready;
    assign rd_done = bus.rvalid && bus.rready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= rv_pkg::IDLE;
            pending   <= 1'b0;
            pc_q      <= '0;
            inst_q    <= '0;
            addr_q    <= '0;
            sdata_q   <= '0;
            rd_q      <= '0;
            load_q    <= '0;
            awvalid_q <= 1'b0;
            wvalid_q  <= 1'b0;
            arvalid_q <= 1'b0;
        end else begin
            case (state)
                rv_pkg::IDLE: begin
                    if (pending) begin
                        // Decode is valid one cycle after capture
                        pending <= 1'b0;
                        if (kind == rv_pkg::KIND_NONE) begin
                            state <= rv_pkg::DONE;
                        end else begin
                            state     <= rv_pkg::ACCESS;
                            awvalid_q <= (kind == rv_pkg::KIND_STORE);
                            wvalid_q  <= (kind == rv_pkg::KIND_STORE);
                            arvalid_q <= (kind == rv_pkg::KIND_LOAD);
                        end
                    end else if (req_i) begin
                        pending <= 1'b1;
                        pc_q    <= pc_i;
                        inst_q  <= inst_i;
                        addr_q  <= addr_i;
                        sdata_q <= store_data_i;
                        rd_q    <= rd_addr_i;
                        load_q  <= '0;
                    end
                end
                rv_pkg::ACCESS: begin
                    // aw and w may complete on different cycles
                    if (bus.awready) begin
                        awvalid_q <= 1'b0;
                    end
                    if (bus.wready) begin
                        wvalid_q <= 1'b0;
                    end
                    if (bus.arready) begin
                        arvalid_q <= 1'b0;
                    end
                    if (rd_done) begin
                        load_q <= load_data_i;
                        state  <= rv_pkg::DONE;
                    end else if (wr_done) begin
                        state <= rv_pkg::DONE;
                    end
                end
                rv_pkg::DONE: begin
                    if (!req_i) begin
                        state <= rv_pkg::IDLE;
                    end
                end
                default: state <= rv_pkg::IDLE;
            endcase
        end
    end

    assign ack_o  = (state == rv_pkg::DONE);
    assign busy_o = (state == rv_pkg::ACCESS);

    // Master side of the bus
    assign bus.awvalid = awvalid_q;
    assign bus.awaddr  = addr_q;
    assign bus.wvalid  = wvalid_q;
    assign bus.wdata   = wdata_i;
    assign bus.wstrb   = wstrb_i;
    assign bus.arvalid = arvalid_q;
    assign bus.araddr  = addr_q;
    assign bus.bready  = busy_o;
    assign bus.rready  = busy_o;

    assign pc_o         = pc_q;
    assign rd_addr_o    = rd_q;
    assign kind_o       = kind;
    assign addr_o       = addr_q;
    assign store_data_o = sdata_q;
    assign load_data_o  = load_q;

endmodule

/* source/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Width of data, address, pc and instruction words
`define MEM_DATA_WIDTH 32

// Register file index width
`define MEM_REG_ADDR_WIDTH 5

// SRAM depth in words is 2**MEM_SRAM_ADDR_BITS
`define MEM_SRAM_ADDR_BITS 8

// Cycles from an accepted SRAM request to its response valid
`define MEM_SRAM_LATENCY 2

`endif

/* source/mem_stage_top.sv */
`timescale 1ns/1ns

module mem_stage_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_i,
    output logic              ack_o,
    output logic              busy_o,
    input  rv_pkg::word_t     pc_i,
    input  rv_pkg::word_t     inst_i,
    input  rv_pkg::word_t     addr_i,
    input  rv_pkg::word_t     store_data_i,
    input  rv_pkg::reg_addr_t rd_addr_i,
    output rv_pkg::word_t     pc_o,
    output rv_pkg::word_t     load_data_o,
    output rv_pkg::reg_addr_t rd_addr_o
);

    axi_lite_if axi_if ();

    rv_pkg::access_size_e mem_size;
    logic                 mem_sign_ext;
    rv_pkg::word_t        mem_addr;
    rv_pkg::word_t        mem_store_data;
    bus_pkg::strb_t       mem_wstrb;
    rv_pkg::word_t        mem_wdata;
    rv_pkg::word_t        mem_load_data;

    mem_access_ctrl mem_access_ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .req_i        (req_i),
        .ack_o        (ack_o),
        .busy_o       (busy_o),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .addr_i       (addr_i),
        .store_data_i (store_data_i),
        .rd_addr_i    (rd_addr_i),
        .pc_o         (pc_o),
        .rd_addr_o    (rd_addr_o),
        .size_o       (mem_size),
        .sign_ext_o   (mem_sign_ext),
        .kind_o       (),
        .addr_o       (mem_addr),
        .store_data_o (mem_store_data),
        .wstrb_i      (mem_wstrb),
        .wdata_i      (mem_wdata),
        .load_data_i  (mem_load_data),
        .load_data_o  (load_data_o),
        .bus          (axi_if.master)
    );

    load_align load_align_i (
        .raw_i      (axi_if.rdata),
        .addr_lo_i  (mem_addr[1:0]),
        .size_i     (mem_size),
        .sign_ext_i (mem_sign_ext),
        .data_o     (mem_load_data)
    );

    store_mask_gen store_mask_gen_i (
        .data_i    (mem_store_data),
        .addr_lo_i (mem_addr[1:0]),
        .size_i    (mem_size),
        .wstrb_o   (mem_wstrb),
        .wdata_o   (mem_wdata)
    );

    axi_lite_sram axi_lite_sram_i (
        .clk (clk),
        .rst (rst),
        .bus (axi_if.slave)
    );

endmodule

/* source/rv_pkg.sv */
`include "mem_params.svh"

package rv_pkg;

    typedef logic [`MEM_DATA_WIDTH-1:0] word_t;
    typedef logic [`MEM_REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;

    // Major opcodes of the memory instructions
    localparam opcode_t OPCODE_LOAD  = 7'b0000011;
    localparam opcode_t OPCODE_STORE = 7'b0100011;

    // Encoded like funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    typedef enum logic [1:0] {
        KIND_NONE,
        KIND_LOAD,
        KIND_STORE
    } access_kind_e;

    // Stage controller states
    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } ctrl_state_e;

endpackage

/* source/store_mask_gen.sv */
`timescale 1ns/1ns

module store_mask_gen (
    input  rv_pkg::word_t        data_i,
    input  logic [1:0]           addr_lo_i,
    input  rv_pkg::access_size_e size_i,
    output bus_pkg::strb_t       wstrb_o,
    output rv_pkg::word_t        wdata_o
);

    always_comb begin
        case (size_i)
            rv_pkg::SIZE_BYTE: begin
                // Byte copied to every lane, strobe picks one
                wdata_o = {4{data_i[7:0]}};
                wstrb_o = bus_pkg::strb_t'(1) << addr_lo_i;
            end
            rv_pkg::SIZE_HALF: begin
                wdata_o = {2{data_i[15:0]}};
                wstrb_o = addr_lo_i[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                wdata_o = data_i;
                wstrb_o = '1;
            end
        endcase
    end

endmodule
